/* verilog/wisc_consts.svh */
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

// datapath width of the execute slice
`define WISC_DATA_W 16

// shift amount, enough for 0 to 15 places
`define WISC_SHAMT_W 4

// instruction opcode field
`define WISC_OP_W 4

// one PADDSB lane
`define WISC_NIB_W 4

`endif

/* verilog/wisc_pkg.sv */
`include "wisc_consts.svh"

package wisc_pkg;

  // instruction opcodes, codes 6 to 15 are unsupported
  typedef enum logic [`WISC_OP_W-1:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_XOR    = 4'd2,
    OP_PADDSB = 4'd3,
    OP_SLL    = 4'd4,
    OP_SRA    = 4'd5
  } opcode_e;

  // internal ALU operation
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_PADDSB,
    ALU_SLL,
    ALU_SRA
  } alu_op_e;

  // flag values and flag update masks share this layout
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flag_t;

  // decode to execute
  typedef struct packed {
    logic                    valid;
    alu_op_e                 alu_op;
    logic [`WISC_DATA_W-1:0] a;
    logic [`WISC_DATA_W-1:0] b;
    flag_t                   upd;   // which flags this op may write
  } exec_req_t;

  // execute to result
  typedef struct packed {
    logic                    valid;
    logic [`WISC_DATA_W-1:0] result;
    flag_t                   flags;
    flag_t                   upd;
  } exec_rsp_t;

endpackage

/* verilog/wisc_shifter.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_shifter (
  input  logic [`WISC_DATA_W-1:0]  shift_in_i,
  input  logic [`WISC_SHAMT_W-1:0] shift_val_i,
  input  logic                     mode_i,      // 0 = SLL, 1 = SRA
  output logic [`WISC_DATA_W-1:0]  shift_out_o
);

  logic [`WISC_DATA_W-1:0] sll_res;
  logic [`WISC_DATA_W-1:0] sra_res;

  // log shifter, stage i moves by 2**i when amount bit i is set
  always_comb begin : sll_stages
    sll_res = shift_in_i;
    for (int i = 0; i < `WISC_SHAMT_W; i++) begin
      if (shift_val_i[i]) begin
        sll_res = sll_res << (1 << i);
      end
    end
  end

  // same stages, sign bit is copied into the vacated top bits
  always_comb begin : sra_stages
    sra_res = shift_in_i;
    for (int i = 0; i < `WISC_SHAMT_W; i++) begin
      if (shift_val_i[i]) begin
        sra_res = $signed(sra_res) >>> (1 << i);
      end
    end
  end

  assign shift_out_o = mode_i ? sra_res : sll_res;

endmodule

/* verilog/wisc_decode.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_decode (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [`WISC_OP_W-1:0]    opcode_i,
  input  logic [`WISC_DATA_W-1:0]  rs_data_i,
  input  logic [`WISC_DATA_W-1:0]  rt_data_i,
  input  logic [`WISC_SHAMT_W-1:0] imm_i,
  output wisc_pkg::exec_req_t      req_o
);

  wisc_pkg::exec_req_t req_d;
  wisc_pkg::exec_req_t req_q;

  // immediate widened to the datapath, used as shift amount
  logic [`WISC_DATA_W-1:0] imm_ext;

  assign imm_ext = {{(`WISC_DATA_W-`WISC_SHAMT_W){1'b0}}, imm_i};

  always_comb begin
    req_d       = '0;
    req_d.valid = 1'b1;
    req_d.a     = rs_data_i;
    req_d.b     = rt_data_i;
    case (wisc_pkg::opcode_e'(opcode_i))
      wisc_pkg::OP_ADD: begin
        req_d.alu_op = wisc_pkg::ALU_ADD;
        req_d.upd    = 3'b111;  // z, v and n
      end
      wisc_pkg::OP_SUB: begin
        req_d.alu_op = wisc_pkg::ALU_SUB;
        req_d.upd    = 3'b111;
      end
      wisc_pkg::OP_XOR: begin
        req_d.alu_op = wisc_pkg::ALU_XOR;
        req_d.upd.z  = 1'b1;
      end
      wisc_pkg::OP_PADDSB: begin
        req_d.alu_op = wisc_pkg::ALU_PADDSB;  // flags untouched
      end
      wisc_pkg::OP_SLL: begin
        req_d.alu_op = wisc_pkg::ALU_SLL;
        req_d.b      = imm_ext;
        req_d.upd.z  = 1'b1;
      end
      wisc_pkg::OP_SRA: begin
        req_d.alu_op = wisc_pkg::ALU_SRA;
        req_d.b      = imm_ext;
        req_d.upd.z  = 1'b1;
      end
      default: begin
        // unknown opcode, instruction is dropped here
        req_d.valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= '0;
    end else if (valid_i) begin
      req_q <= req_d;
    end else begin
      req_q.valid <= 1'b0;  // payload holds
    end
  end

  assign req_o = req_q;

endmodule

/* verilog/wisc_alu.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_alu (
  input  wisc_pkg::exec_req_t req_i,
  output wisc_pkg::exec_rsp_t rsp_o
);

  localparam int LANES = `WISC_DATA_W / `WISC_NIB_W;

  // clamp values for the full word
  localparam logic [`WISC_DATA_W-1:0] WORD_MAX = {1'b0, {(`WISC_DATA_W-1){1'b1}}};
  localparam logic [`WISC_DATA_W-1:0] WORD_MIN = {1'b1, {(`WISC_DATA_W-1){1'b0}}};

  // clamp values for one nibble lane, 7 and -8
  localparam logic [`WISC_NIB_W-1:0] NIB_MAX = {1'b0, {(`WISC_NIB_W-1){1'b1}}};
  localparam logic [`WISC_NIB_W-1:0] NIB_MIN = {1'b1, {(`WISC_NIB_W-1){1'b0}}};

  logic [`WISC_DATA_W-1:0] sum;
  logic [`WISC_DATA_W-1:0] diff;
  logic                    add_ovf;
  logic                    sub_ovf;
  logic [`WISC_DATA_W-1:0] sat_sum;
  logic [`WISC_DATA_W-1:0] sat_diff;
  logic [`WISC_DATA_W-1:0] xor_res;
  logic [`WISC_DATA_W-1:0] paddsb_res;
  logic [`WISC_DATA_W-1:0] shift_res;
  logic [`WISC_DATA_W-1:0] result;
  logic                    ovf;

  assign sum  = req_i.a + req_i.b;
  assign diff = req_i.a - req_i.b;

  // signed overflow, checked on the wrapped value
  assign add_ovf = (req_i.a[`WISC_DATA_W-1] == req_i.b[`WISC_DATA_W-1]) &&
                   (sum[`WISC_DATA_W-1] != req_i.a[`WISC_DATA_W-1]);
  assign sub_ovf = (req_i.a[`WISC_DATA_W-1] != req_i.b[`WISC_DATA_W-1]) &&
                   (diff[`WISC_DATA_W-1] != req_i.a[`WISC_DATA_W-1]);

  // on overflow the sign of a tells which rail was crossed
  assign sat_sum  = add_ovf ? (req_i.a[`WISC_DATA_W-1] ? WORD_MIN : WORD_MAX) : sum;
  assign sat_diff = sub_ovf ? (req_i.a[`WISC_DATA_W-1] ? WORD_MIN : WORD_MAX) : diff;

  assign xor_res = req_i.a ^ req_i.b;

  always_comb begin : paddsb_lanes
    logic [`WISC_NIB_W-1:0] lane_a;
    logic [`WISC_NIB_W-1:0] lane_b;
    logic [`WISC_NIB_W-1:0] lane_s;
    paddsb_res = '0;
    for (int l = 0; l < LANES; l++) begin
      lane_a = req_i.a[l*`WISC_NIB_W +: `WISC_NIB_W];
      lane_b = req_i.b[l*`WISC_NIB_W +: `WISC_NIB_W];
      lane_s = lane_a + lane_b;
      if ((lane_a[`WISC_NIB_W-1] == lane_b[`WISC_NIB_W-1]) &&
          (lane_s[`WISC_NIB_W-1] != lane_a[`WISC_NIB_W-1])) begin
        lane_s = lane_a[`WISC_NIB_W-1] ? NIB_MIN : NIB_MAX;
      end
      paddsb_res[l*`WISC_NIB_W +: `WISC_NIB_W] = lane_s;
    end
  end

  // shift amount is the low bits of b, decode put the immediate there
  wisc_shifter u_shifter (
    .shift_in_i  (req_i.a),
    .shift_val_i (req_i.b[`WISC_SHAMT_W-1:0]),
    .mode_i      (req_i.alu_op == wisc_pkg::ALU_SRA),
    .shift_out_o (shift_res)
  );

  always_comb begin
    ovf = 1'b0;
    case (req_i.alu_op)
      wisc_pkg::ALU_ADD: begin
        result = sat_sum;
        ovf    = add_ovf;
      end
      wisc_pkg::ALU_SUB: begin
        result = sat_diff;
        ovf    = sub_ovf;
      end
      wisc_pkg::ALU_XOR:    result = xor_res;
      wisc_pkg::ALU_PADDSB: result = paddsb_res;
      default:              result = shift_res;  // SLL and SRA
    endcase
  end

  assign rsp_o.valid   = req_i.valid;
  assign rsp_o.result  = result;
  assign rsp_o.flags.z = (result == '0);
  assign rsp_o.flags.v = ovf;                     // before saturation
  assign rsp_o.flags.n = result[`WISC_DATA_W-1];  // after saturation
  assign rsp_o.upd     = req_i.upd;

endmodule

/* verilog/wisc_result.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_result (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  wisc_pkg::exec_rsp_t     rsp_i,
  output logic                    valid_o,
  output logic [`WISC_DATA_W-1:0] result_o,
  output wisc_pkg::flag_t         flags_o
);

  logic                    valid_q;
  logic [`WISC_DATA_W-1:0] result_q;
  wisc_pkg::flag_t         flags_q;

  // one-cycle strobe per finished instruction
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rsp_i.valid;
    end
  end

  // result stays at the last value between instructions
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
    end else if (rsp_i.valid) begin
      result_q <= rsp_i.result;
    end
  end

  // flags persist across instructions, each bit written only if its mask bit is set
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flags_q <= '0;
    end else if (rsp_i.valid) begin
      if (rsp_i.upd.z) begin
        flags_q.z <= rsp_i.flags.z;
      end
      if (rsp_i.upd.v) begin
        flags_q.v <= rsp_i.flags.v;
      end
      if (rsp_i.upd.n) begin
        flags_q.n <= rsp_i.flags.n;
      end
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign flags_o  = flags_q;

endmodule

/* verilog/wisc_exec_top.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_exec_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [`WISC_OP_W-1:0]    opcode_i,
  input  logic [`WISC_DATA_W-1:0]  rs_data_i,
  input  logic [`WISC_DATA_W-1:0]  rt_data_i,
  input  logic [`WISC_SHAMT_W-1:0] imm_i,
  output logic                     valid_o,
  output logic [`WISC_DATA_W-1:0]  result_o,
  output wisc_pkg::flag_t          flags_o
);

  wisc_pkg::exec_req_t req;  // registered, decode to execute
  wisc_pkg::exec_rsp_t rsp;  // combinational, execute to result

  wisc_decode u_decode (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (valid_i),
    .opcode_i  (opcode_i),
    .rs_data_i (rs_data_i),
    .rt_data_i (rt_data_i),
    .imm_i     (imm_i),
    .req_o     (req)
  );

  wisc_alu u_alu (
    .req_i (req),
    .rsp_o (rsp)
  );

  wisc_result u_result (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .rsp_i    (rsp),
    .valid_o  (valid_o),
    .result_o (result_o),
    .flags_o  (flags_o)
  );

endmodule

/* verif/wisc_exec_chk.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_exec_chk (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  wisc_pkg::exec_rsp_t rsp_i,
  input  logic                valid_i,
  input  wisc_pkg::flag_t     flags_i
);

  int fail_cnt = 0;  // failed assertion count

  // outputs sit at zero while reset is held
  valid_low_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (!valid_i && flags_i == '0))
    else begin
      $error("valid_o or flags_o not zero during reset");
      fail_cnt++;
    end

  // flags hold through cycles with no valid response
  flags_hold_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !rsp_i.valid |=> $stable(flags_i))
    else begin
      $error("flags_o changed without a valid response");
      fail_cnt++;
    end

endmodule

bind wisc_result wisc_exec_chk u_chk (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .rsp_i   (rsp_i),
  .valid_i (valid_o),
  .flags_i (flags_o)
);

/* verif/wisc_exec_monitor.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_exec_monitor (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [`WISC_OP_W-1:0]    opcode_i,
  input  logic [`WISC_DATA_W-1:0]  rs_data_i,
  input  logic [`WISC_DATA_W-1:0]  rt_data_i,
  input  logic [`WISC_SHAMT_W-1:0] imm_i,
  input  logic                     dut_valid_i,
  input  logic [`WISC_DATA_W-1:0]  dut_result_i,
  input  wisc_pkg::flag_t          dut_flags_i,
  input  logic                     end_check_i,
  output int                       value_err_o,
  output int                       proto_err_o,
  output int                       checked_o,
  output int                       pending_o
);

  typedef struct packed {
    logic [`WISC_DATA_W-1:0] result;
    wisc_pkg::flag_t         flags;
    logic [31:0]             cycle;  // issue cycle
  } expect_t;

  expect_t         exp_q[$];
  expect_t         exp;
  wisc_pkg::flag_t model_flags = '0;
  int              cycle = 0;
  int              value_err = 0;
  int              proto_err = 0;
  int              checked = 0;

  function automatic int clamp(input int x, input int lo, input int hi);
    if (x > hi) begin
      return hi;
    end
    if (x < lo) begin
      return lo;
    end
    return x;
  endfunction

  // expected result and flags from the ISA rules
  function automatic expect_t predict(input logic [`WISC_OP_W-1:0] op,
                                      input logic [`WISC_DATA_W-1:0] a,
                                      input logic [`WISC_DATA_W-1:0] b,
                                      input logic [`WISC_SHAMT_W-1:0] imm,
                                      input wisc_pkg::flag_t cur);
    expect_t e;
    int      full;
    int      lane;
    e       = '0;
    e.flags = cur;
    case (wisc_pkg::opcode_e'(op))
      wisc_pkg::OP_ADD, wisc_pkg::OP_SUB: begin
        full = (op == wisc_pkg::OP_ADD) ? int'($signed(a)) + int'($signed(b))
                                        : int'($signed(a)) - int'($signed(b));
        lane      = clamp(full, -32768, 32767);
        e.result  = lane[`WISC_DATA_W-1:0];
        e.flags.v = (full != lane);  // exact value did not fit
        e.flags.n = e.result[`WISC_DATA_W-1];
      end
      wisc_pkg::OP_XOR: e.result = a ^ b;
      wisc_pkg::OP_PADDSB: begin
        for (int l = 0; l < `WISC_DATA_W / `WISC_NIB_W; l++) begin
          lane = clamp(int'($signed(a[l*`WISC_NIB_W +: `WISC_NIB_W])) +
                       int'($signed(b[l*`WISC_NIB_W +: `WISC_NIB_W])), -8, 7);
          e.result[l*`WISC_NIB_W +: `WISC_NIB_W] = lane[`WISC_NIB_W-1:0];
        end
      end
      wisc_pkg::OP_SLL: e.result = a << imm;
      wisc_pkg::OP_SRA: begin
        full     = int'($signed(a)) >>> imm;  // sign fills from the top
        e.result = full[`WISC_DATA_W-1:0];
      end
      default: e.result = '0;
    endcase
    if (op != wisc_pkg::OP_PADDSB) begin
      e.flags.z = (e.result == '0);
    end
    return e;
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      if (dut_valid_i !== 1'b0 || dut_result_i !== '0 || dut_flags_i !== '0) begin
        $display("ERR %0t: outputs not zero in reset, valid %b result %h flags %b",
                 $time, dut_valid_i, dut_result_i, dut_flags_i);
        value_err++;
      end
      exp_q.delete();
      model_flags = '0;
    end else begin
      if (dut_valid_i) begin
        if (exp_q.size() == 0) begin
          $display("valid_o went high at %0t with no instruction outstanding", $time);
          proto_err++;
        end else begin
          exp = exp_q.pop_front();
          checked++;
          if (cycle != int'(exp.cycle) + 2) begin
            $display("result at %0t came %0d cycles after its valid_i instead of 2",
                     $time, cycle - int'(exp.cycle));
            proto_err++;
          end
          if (dut_result_i !== exp.result || dut_flags_i !== exp.flags) begin
            $display("ERR %0t: result %h flags %b, expected %h flags %b", $time,
                     dut_result_i, dut_flags_i, exp.result, exp.flags);
            value_err++;
          end
        end
      end
      // opcodes above SRA are dropped by the DUT
      if (valid_i && opcode_i <= wisc_pkg::OP_SRA) begin
        exp       = predict(opcode_i, rs_data_i, rt_data_i, imm_i, model_flags);
        exp.cycle = cycle;
        model_flags = exp.flags;
        exp_q.push_back(exp);
      end
      if (end_check_i && exp_q.size() != 0) begin
        $display("%0d expected results never appeared on valid_o", exp_q.size());
        proto_err++;
        exp_q.delete();
      end
    end
    cycle++;
  end

  assign value_err_o = value_err;
  assign proto_err_o = proto_err;
  assign checked_o   = checked;
  assign pending_o   = exp_q.size();

endmodule

/* verif/wisc_exec_tb.sv */
`timescale 1ns/1ns
`include "wisc_consts.svh"

module wisc_exec_tb;

  localparam int NUM_SLOTS   = 2000;
  localparam int RST_CYCLES  = 8;
  localparam int DRAIN_MAX   = 4;                // pipeline is two deep
  localparam int TIMEOUT_CYC = NUM_SLOTS + 20;

  // one instruction slot as driven into the DUT
  typedef struct packed {
    logic                     valid;
    logic [`WISC_OP_W-1:0]    opcode;
    logic [`WISC_DATA_W-1:0]  rs;
    logic [`WISC_DATA_W-1:0]  rt;
    logic [`WISC_SHAMT_W-1:0] imm;
  } stim_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    end_check;
  stim_t                   stim;
  logic                    valid_out;
  logic [`WISC_DATA_W-1:0] result;
  wisc_pkg::flag_t         flags;
  integer                  seed;
  int                      value_err;
  int                      proto_err;
  int                      checked;
  int                      pending;
  int                      cycles = 0;
  int                      total;
  int                      drain;

  always #5 clk = ~clk;

  wisc_exec_top dut_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .valid_i   (stim.valid),
    .opcode_i  (stim.opcode),
    .rs_data_i (stim.rs),
    .rt_data_i (stim.rt),
    .imm_i     (stim.imm),
    .valid_o   (valid_out),
    .result_o  (result),
    .flags_o   (flags)
  );

  wisc_exec_monitor u_mon (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .valid_i      (stim.valid),
    .opcode_i     (stim.opcode),
    .rs_data_i    (stim.rs),
    .rt_data_i    (stim.rt),
    .imm_i        (stim.imm),
    .dut_valid_i  (valid_out),
    .dut_result_i (result),
    .dut_flags_i  (flags),
    .end_check_i  (end_check),
    .value_err_o  (value_err),
    .proto_err_o  (proto_err),
    .checked_o    (checked),
    .pending_o    (pending)
  );

  // mostly corner values so saturation and zero results show up often
  function automatic logic [`WISC_DATA_W-1:0] pick_operand();
    logic [31:0] rnd;
    rnd = $random(seed);
    case (rnd[18:16])
      3'd0:    return 16'h7fff;
      3'd1:    return 16'h8000;
      3'd2:    return 16'h0000;
      3'd3:    return 16'hffff;
      3'd4:    return rnd[0] ? 16'h7777 : 16'h8888;  // all lanes at a rail
      default: return rnd[15:0];
    endcase
  endfunction

  task automatic drive_slot();
    logic [31:0] rnd;
    rnd         = $random(seed);
    stim.valid  = (rnd[7:0] < 8'd205);  // about 80 percent
    stim.opcode = rnd[11:8];
    stim.imm    = rnd[15:12];
    stim.rs     = pick_operand();
    stim.rt     = pick_operand();
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cycles <= cycles + 1;
    end
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout, run not finished %0d cycles after reset", TIMEOUT_CYC);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    seed      = 32'h7700ff1a;
    rst_n     = 1'b0;
    stim      = '0;
    end_check = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      drive_slot();
      @(posedge clk);
      #1;
    end
    stim.valid = 1'b0;
    drain      = 0;
    while (pending != 0 && drain < DRAIN_MAX) begin
      @(posedge clk);
      #1;
      drain++;
    end
    end_check = 1'b1;
    @(posedge clk);
    #1;
    total = value_err + proto_err + dut_i.u_result.u_chk.fail_cnt;
    if (checked == 0) begin
      $display("no results were checked, valid_o never went high");
      total = total + 1;
    end
    $display("%0d results checked, %0d value errors, %0d protocol errors, %0d assertion fails",
             checked, value_err, proto_err, dut_i.u_result.u_chk.fail_cnt);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+verilog
verilog/wisc_pkg.sv
verilog/wisc_shifter.sv
verilog/wisc_decode.sv
verilog/wisc_alu.sv
verilog/wisc_result.sv
verilog/wisc_exec_top.sv
verif/wisc_exec_chk.sv
verif/wisc_exec_monitor.sv
verif/wisc_exec_tb.sv

/* Makefile */
# Verilator build and run for the execute slice testbench

VERILATOR ?= verilator
TOP       ?= wisc_exec_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then \
	  echo "simulation exited with status $$status"; exit 1; \
	fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "failure reported in $(LOG)"; exit 1; \
	fi; \
	echo "no failure reported in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
